// File: Makefile
TOP := tb_mpmc

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module $(TOP) -f all.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir

// File: all.f
hdl/mpmc_cfg_pkg.sv
hdl/mpmc_bus_pkg.sv
hdl/mpmc_fifo.sv
hdl/mpmc_waddr_gen.sv
hdl/mpmc_ctrl_sm.sv
hdl/mpmc_rdata_track.sv
hdl/mpmc_top.sv
testbench/tb_mpmc.sv

// File: hdl/mpmc_bus_pkg.sv
package mpmc_bus_pkg;

	// ==================================================
	// Client side
	// ==================================================

	// Burst command from the client
	// num_strips is the index of the last strip, so a value of 0 moves one strip
	typedef struct packed {
		logic                    we;
		logic [31:0]             addr_base;
		mpmc_cfg_pkg::mpmc_idx_t num_strips;
		logic [3:0]              tag;
	} mpmc_cmd_t;

	// One strip of data, used for write data and raw read returns alike
	typedef logic [mpmc_cfg_pkg::STRIP_BITS-1:0] mpmc_strip_t;

	// Read strip handed back to the client with its label
	typedef struct packed {
		logic [3:0]              tag;
		mpmc_cfg_pkg::mpmc_idx_t idx;
		mpmc_strip_t             data;
	} mpmc_rdata_t;

	// Completion of one command, we tells a write from a read
	typedef struct packed {
		logic [3:0] tag;
		logic       we;
	} mpmc_done_t;

	// ==================================================
	// Memory side
	// ==================================================

	// One strip command to the memory interface
	// wdata carries zero on reads
	typedef struct packed {
		logic        we;
		logic [31:0] addr;
		mpmc_strip_t wdata;
	} mpmc_app_cmd_t;

	// Read waiting for its strips to come back
	typedef struct packed {
		logic [3:0]              tag;
		mpmc_cfg_pkg::mpmc_idx_t num_strips;
	} mpmc_rd_rec_t;

endpackage

// File: hdl/mpmc_cfg_pkg.sv
package mpmc_cfg_pkg;

	// ==================================================
	// Controller state encoding
	// ==================================================

	// One burst runs IDLE, PRESET1, PRESET2, then WRITE_DATA or READ_CMD,
	// and ends in DONE before the next command is taken
	typedef enum logic [3:0] {
		IDLE       = 4'd0,
		PRESET1    = 4'd1,
		PRESET2    = 4'd2,
		WRITE_DATA = 4'd3,
		READ_CMD   = 4'd4,
		DONE       = 4'd5
	} mpmc_state_t;

	// ==================================================
	// Strip geometry
	// ==================================================

	// A strip is the unit moved per memory command
	localparam int STRIP_BYTES = 16;
	localparam int STRIP_BITS  = 128;

	// Bursts carry one to eight strips, so an index fits in three bits
	localparam int MAX_STRIPS = 8;
	typedef logic [$clog2(MAX_STRIPS)-1:0] mpmc_idx_t;

	// Address value held by the generator until the first burst loads it
	localparam logic [31:0] ADDR_RESET = 32'h1FFFFFFF;

	// ==================================================
	// FIFO depths
	// ==================================================

	localparam int CMD_DEPTH = 16;
	localparam int WD_DEPTH  = 64;
	// Outstanding reads in flight to the memory at one time
	localparam int RD_DEPTH  = 8;

endpackage

// File: hdl/mpmc_ctrl_sm.sv
`timescale 1ns/100ps

module mpmc_ctrl_sm (
	input  logic                        clk,
	input  logic                        rst,
	// Command FIFO
	input  logic                        cmd_empty,
	input  mpmc_bus_pkg::mpmc_cmd_t     cmd_head,
	output logic                        cmd_pop,
	// Write-strip FIFO
	input  logic                        wd_empty,
	input  mpmc_bus_pkg::mpmc_strip_t   wd_head,
	output logic                        wd_pop,
	// Address generator
	output mpmc_cfg_pkg::mpmc_state_t   state,
	output logic                        issue,
	output mpmc_cfg_pkg::mpmc_idx_t     strip_cnt,
	output mpmc_bus_pkg::mpmc_cmd_t     cur_cmd,
	input  logic [31:0]                 addr,
	// Memory interface
	output logic                        app_strobe,
	output mpmc_bus_pkg::mpmc_app_cmd_t app_cmd,
	// Read tracker
	output logic                        rd_push,
	output mpmc_bus_pkg::mpmc_rd_rec_t  rd_rec,
	input  logic                        rd_done_busy,
	// Write completion
	output logic                        wr_done_strobe,
	output mpmc_bus_pkg::mpmc_done_t    wr_done
);

	import mpmc_cfg_pkg::*;

	mpmc_state_t state_nxt;
	logic        last_strip;

	// ==================================================
	// Strip issue
	// ==================================================

	// Writes wait for data, reads go out back to back
	assign issue = ((state == WRITE_DATA) && !wd_empty) || (state == READ_CMD);
	assign last_strip = (strip_cnt == cur_cmd.num_strips);

	assign wd_pop = issue && (state == WRITE_DATA);

	// The generator already points at the current strip, so the command is
	// formed from its output in the same cycle
	assign app_strobe    = issue;
	assign app_cmd.we    = cur_cmd.we;
	assign app_cmd.addr  = addr;
	assign app_cmd.wdata = cur_cmd.we ? wd_head : '0;

	// The read tracker learns about a read as its first strip leaves
	assign rd_push           = issue && (state == READ_CMD) && (strip_cnt == '0);
	assign rd_rec.tag        = cur_cmd.tag;
	assign rd_rec.num_strips = cur_cmd.num_strips;

	// ==================================================
	// Completion
	// ==================================================

	// Only writes report here, reads report from the tracker
	// If the tracker owns the done output this cycle, DONE is held and the
	// write done goes out one cycle later
	assign wr_done_strobe = (state == DONE) && cur_cmd.we && !rd_done_busy;
	assign wr_done.tag    = cur_cmd.tag;
	assign wr_done.we     = 1'b1;

	// ==================================================
	// FSM
	// ==================================================

	assign cmd_pop = (state == IDLE) && !cmd_empty;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:
				if (!cmd_empty)
					state_nxt = PRESET1;
			PRESET1:
				state_nxt = PRESET2;
			PRESET2:
				state_nxt = cur_cmd.we ? WRITE_DATA : READ_CMD;
			WRITE_DATA, READ_CMD:
				if (issue && last_strip)
					state_nxt = DONE;
			DONE:
				if (!(cur_cmd.we && rd_done_busy))
					state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= IDLE;
			strip_cnt <= '0;
		end else begin
			state <= state_nxt;
			// Count restarts for each burst before the first strip goes out
			if (state == PRESET2)
				strip_cnt <= '0;
			else if (issue)
				strip_cnt <= strip_cnt + 1'b1;
		end
	end

	// The head is captured on the popping edge, so cur_cmd is valid from
	// PRESET1 until the burst ends
	always_ff @(posedge clk) begin
		if (cmd_pop)
			cur_cmd <= cmd_head;
	end

endmodule

// File: hdl/mpmc_fifo.sv
`timescale 1ns/100ps

module mpmc_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int  depth     = 4
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     push,
	input  payload_t din,
	input  logic     pop,
	output payload_t dout,
	output logic     empty,
	output logic     full
);

	// Pointer and count widths, the count needs one more state than the pointers
	localparam int AW = (depth > 1) ? $clog2(depth) : 1;
	localparam int CW = $clog2(depth + 1);

	payload_t       mem [depth];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic [CW-1:0]  count;
	logic           do_push;
	logic           do_pop;

	assign empty = (count == '0);
	assign full  = (count == CW'(depth));

	// Pushes into a full buffer and pops from an empty one are dropped
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// Head is visible without a pop
	assign dout = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap explicitly so any depth works, not only powers of two
			if (do_push)
				wr_ptr <= (wr_ptr == AW'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == AW'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			// A push and a pop together leave the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: hdl/mpmc_rdata_track.sv
`timescale 1ns/100ps

module mpmc_rdata_track (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       rec_push,
	input  mpmc_bus_pkg::mpmc_rd_rec_t rec,
	input  logic                       app_rd_strobe,
	input  mpmc_bus_pkg::mpmc_strip_t  app_rdata,
	output logic                       rd_strobe,
	output mpmc_bus_pkg::mpmc_rdata_t  rd,
	output logic                       done_strobe,
	output mpmc_bus_pkg::mpmc_done_t   done
);

	import mpmc_cfg_pkg::*;
	import mpmc_bus_pkg::*;

	mpmc_rd_rec_t head;
	logic         rec_empty;
	logic         rec_pop;
	mpmc_idx_t    rx_cnt;
	logic         rx_last;

	// Reads come back in issue order, so the oldest record always owns the
	// strip that is arriving
	mpmc_fifo #(
		.payload_t (mpmc_rd_rec_t),
		.depth     (RD_DEPTH)
	) rec_fifo (
		.clk   (clk),
		.rst   (rst),
		.push  (rec_push),
		.din   (rec),
		.pop   (rec_pop),
		.dout  (head),
		.empty (rec_empty),
		.full  ()
	);

	assign rx_last = (rx_cnt == head.num_strips);
	// Record retires with its final strip
	assign rec_pop = app_rd_strobe && rx_last && !rec_empty;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_strobe   <= 1'b0;
			done_strobe <= 1'b0;
			rx_cnt      <= '0;
		end else begin
			rd_strobe   <= app_rd_strobe;
			done_strobe <= rec_pop;
			if (app_rd_strobe)
				rx_cnt <= rx_last ? '0 : rx_cnt + 1'b1;
		end
	end

	// Labels go out one cycle after the strip, together with the strobe
	always_ff @(posedge clk) begin
		if (app_rd_strobe) begin
			rd.tag  <= head.tag;
			rd.idx  <= rx_cnt;
			rd.data <= app_rdata;
		end
		if (rec_pop) begin
			done.tag <= head.tag;
			done.we  <= 1'b0;
		end
	end

endmodule

// File: hdl/mpmc_top.sv
`timescale 1ns/100ps

module mpmc_top (
	input  logic                        clk,
	input  logic                        rst,
	// Client requests
	input  logic                        cmd_strobe,
	input  mpmc_bus_pkg::mpmc_cmd_t     cmd,
	input  logic                        wd_strobe,
	input  mpmc_bus_pkg::mpmc_strip_t   wd,
	// Memory interface
	output logic                        app_strobe,
	output mpmc_bus_pkg::mpmc_app_cmd_t app_cmd,
	input  logic                        app_rd_strobe,
	input  mpmc_bus_pkg::mpmc_strip_t   app_rdata,
	// Client responses
	output logic                        rd_strobe,
	output mpmc_bus_pkg::mpmc_rdata_t   rd,
	output logic                        done_strobe,
	output mpmc_bus_pkg::mpmc_done_t    done
);

	import mpmc_cfg_pkg::*;
	import mpmc_bus_pkg::*;

	logic         cmd_empty;
	logic         cmd_pop;
	mpmc_cmd_t    cmd_head;
	logic         wd_empty;
	logic         wd_pop;
	mpmc_strip_t  wd_head;
	mpmc_state_t  state;
	logic         issue;
	mpmc_idx_t    strip_cnt;
	mpmc_cmd_t    cur_cmd;
	logic [31:0]  addr;
	logic         rd_push;
	mpmc_rd_rec_t rd_rec;
	logic         wr_done_strobe;
	mpmc_done_t   wr_done;
	logic         trk_done_strobe;
	mpmc_done_t   trk_done;

	// ==================================================
	// Input queues
	// ==================================================

	// No back-pressure to the client, full outputs are left open
	mpmc_fifo #(.payload_t(mpmc_cmd_t), .depth(CMD_DEPTH)) cmd_fifo (
		.clk(clk), .rst(rst), .push(cmd_strobe), .din(cmd), .pop(cmd_pop),
		.dout(cmd_head), .empty(cmd_empty), .full()
	);

	mpmc_fifo #(.payload_t(mpmc_strip_t), .depth(WD_DEPTH)) wd_fifo (
		.clk(clk), .rst(rst), .push(wd_strobe), .din(wd), .pop(wd_pop),
		.dout(wd_head), .empty(wd_empty), .full()
	);

	// ==================================================
	// Burst sequencing
	// ==================================================

	mpmc_ctrl_sm ctrl_sm (
		.clk(clk), .rst(rst),
		.cmd_empty(cmd_empty), .cmd_head(cmd_head), .cmd_pop(cmd_pop),
		.wd_empty(wd_empty), .wd_head(wd_head), .wd_pop(wd_pop),
		.state(state), .issue(issue), .strip_cnt(strip_cnt), .cur_cmd(cur_cmd),
		.addr(addr), .app_strobe(app_strobe), .app_cmd(app_cmd),
		.rd_push(rd_push), .rd_rec(rd_rec), .rd_done_busy(trk_done_strobe),
		.wr_done_strobe(wr_done_strobe), .wr_done(wr_done)
	);

	mpmc_waddr_gen waddr_gen (
		.clk(clk), .rst(rst), .state(state), .valid(issue),
		.num_strips(cur_cmd.num_strips), .strip_cnt(strip_cnt),
		.addr_base(cur_cmd.addr_base), .addr(addr)
	);

	mpmc_rdata_track rdata_track (
		.clk(clk), .rst(rst), .rec_push(rd_push), .rec(rd_rec),
		.app_rd_strobe(app_rd_strobe), .app_rdata(app_rdata),
		.rd_strobe(rd_strobe), .rd(rd),
		.done_strobe(trk_done_strobe), .done(trk_done)
	);

	// Read completions win, the FSM holds its write done back a cycle
	assign done_strobe = trk_done_strobe || wr_done_strobe;
	assign done        = trk_done_strobe ? trk_done : wr_done;

endmodule

// File: hdl/mpmc_waddr_gen.sv
`timescale 1ns/100ps

module mpmc_waddr_gen (
	input  logic                      clk,
	input  logic                      rst,
	input  mpmc_cfg_pkg::mpmc_state_t state,
	input  logic                      valid,
	input  mpmc_cfg_pkg::mpmc_idx_t   num_strips,
	input  mpmc_cfg_pkg::mpmc_idx_t   strip_cnt,
	input  logic [31:0]               addr_base,
	output logic [31:0]               addr
);

	import mpmc_cfg_pkg::*;

	// Bits below this stay fixed, they address bytes inside a strip
	localparam int LOW = $clog2(STRIP_BYTES);

	// The burst base is taken during PRESET2 so the first strip sees it directly
	// Each issued strip moves the address to the next strip, except the last
	// one, which leaves the address on the final strip of the burst
	always_ff @(posedge clk) begin
		if (rst) begin
			addr <= ADDR_RESET;
		end else begin
			if (state == PRESET2)
				addr <= addr_base;
			else if (valid && strip_cnt != num_strips)
				// Carry out of bit 31 is lost, the strip address wraps
				addr[31:LOW] <= addr[31:LOW] + 1'b1;
		end
	end

endmodule

// File: testbench/tb_mpmc.sv
`timescale 1ns/100ps

module tb_mpmc;

	import mpmc_cfg_pkg::*;
	import mpmc_bus_pkg::*;

	// Number of commands over all tests, which sets the watchdog at 40 cycles each
	localparam int TOTAL_CMDS = 56;

	logic          clk;
	logic          rst = 1'b1;
	logic          cmd_strobe = 1'b0;
	mpmc_cmd_t     cmd = '0;
	logic          wd_strobe = 1'b0;
	mpmc_strip_t   wd = '0;
	logic          app_strobe;
	mpmc_app_cmd_t app_cmd;
	logic          app_rd_strobe = 1'b0;
	mpmc_strip_t   app_rdata = '0;
	logic          rd_strobe;
	mpmc_rdata_t   rd;
	logic          done_strobe;
	mpmc_done_t    done;

	logic [31:0]   stim_lfsr = 32'hfc6594f3;
	logic [31:0]   mem_lfsr = 32'hfc6594f3;
	logic [3:0]    next_tag = '0;
	string         test_name = "reset";
	int            cyc = 0;
	int            last_due = 0;
	int            app_errs = 0;
	int            rd_errs = 0;
	int            done_errs = 0;
	int            left_errs = 0;

	// Expected traffic is queued in order when the stimulus is made
	mpmc_app_cmd_t app_q [$];
	mpmc_rdata_t   rd_q [$];
	mpmc_done_t    wr_done_q [$];
	mpmc_done_t    rd_done_q [$];
	mpmc_strip_t   shadow [logic [27:0]];
	// Memory model storage and the read returns still in flight
	mpmc_strip_t   mem [logic [27:0]];
	mpmc_strip_t   ret_q [$];
	int            due_q [$];

	mpmc_top dut0 (
		.clk(clk), .rst(rst), .cmd_strobe(cmd_strobe), .cmd(cmd),
		.wd_strobe(wd_strobe), .wd(wd), .app_strobe(app_strobe), .app_cmd(app_cmd),
		.app_rd_strobe(app_rd_strobe), .app_rdata(app_rdata),
		.rd_strobe(rd_strobe), .rd(rd), .done_strobe(done_strobe), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// Random numbers and reference functions
	// ==================================================

	// One Galois step where the bit shifted out is the bit taken
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], stim_lfsr[0]};
			stim_lfsr = lfsr_step(stim_lfsr);
		end
		return r;
	endfunction

	function automatic mpmc_strip_t rand_strip();
		mpmc_strip_t s;
		for (int i = 0; i < 4; i++)
			s[i*32 +: 32] = rand_bits(32);
		return s;
	endfunction

	// Strip k sits 16 bytes per index above the base and keeps the low nibble
	function automatic logic [31:0] strip_addr(input logic [31:0] base, input int k);
		logic [27:0] line;
		line = base[31:4] + 28'(k);
		return {line, base[3:0]};
	endfunction

	// A strip that was never written holds a pattern built from its whole address
	function automatic mpmc_strip_t fill_pattern(input logic [27:0] line);
		logic [31:0] a;
		a = {line, 4'h0};
		return {a, ~a, a ^ 32'hA5C35A3C, {a[15:0], a[31:16]}};
	endfunction

	function automatic mpmc_strip_t shadow_data(input logic [31:0] addr);
		if (shadow.exists(addr[31:4]))
			return shadow[addr[31:4]];
		return fill_pattern(addr[31:4]);
	endfunction

	// ==================================================
	// Stimulus tasks
	// ==================================================

	task automatic step(input logic cs, input mpmc_cmd_t c, input logic ws, input mpmc_strip_t w);
		@(posedge clk);
		cmd_strobe <= cs;
		cmd        <= c;
		wd_strobe  <= ws;
		wd         <= w;
	endtask

	// Queues everything the command should produce and then drives it
	task automatic send_cmd(input logic we, input logic [31:0] base, input mpmc_idx_t n,
			input logic strips_first);
		mpmc_cmd_t     c;
		mpmc_strip_t   data [MAX_STRIPS];
		mpmc_app_cmd_t a;
		mpmc_rdata_t   r;
		mpmc_done_t    d;
		logic [31:0]   sa;
		c.we        = we;
		c.addr_base = base;
		c.num_strips = n;
		c.tag       = next_tag;
		next_tag    = next_tag + 4'd1;
		for (int k = 0; k <= int'(n); k++) begin
			sa     = strip_addr(base, k);
			a.we   = we;
			a.addr = sa;
			a.wdata = '0;
			if (we) begin
				data[k] = rand_strip();
				shadow[sa[31:4]] = data[k];
				a.wdata = data[k];
			end else begin
				r.tag  = c.tag;
				r.idx  = k[2:0];
				r.data = shadow_data(sa);
				rd_q.push_back(r);
			end
			app_q.push_back(a);
		end
		d.tag = c.tag;
		d.we  = we;
		if (we)
			wr_done_q.push_back(d);
		else
			rd_done_q.push_back(d);
		if (!(we && strips_first))
			step(1'b1, c, 1'b0, '0);
		for (int k = 0; we && k <= int'(n); k++)
			step(1'b0, c, 1'b1, data[k]);
		if (we && strips_first)
			step(1'b1, c, 1'b0, '0);
	endtask

	// Waits until few enough commands are open that no FIFO can overflow
	task automatic drain(input int limit);
		step(1'b0, '0, 1'b0, '0);
		while (wr_done_q.size() + rd_done_q.size() > limit)
			@(posedge clk);
	endtask

	initial begin
		logic [31:0] base;
		logic [31:0] r;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		// Any strobe here has nothing queued and is flagged
		test_name = "idle";
		repeat (20) @(posedge clk);
		test_name = "single_strip";
		base = rand_bits(32);
		send_cmd(1'b1, base, 3'd0, 1'b0);
		send_cmd(1'b0, base, 3'd0, 1'b0);
		drain(0);
		test_name = "eight_strip";
		for (int i = 0; i < 3; i++) begin
			base = rand_bits(32);
			send_cmd(1'b1, base, 3'd7, 1'b0);
			send_cmd(1'b0, base, 3'd7, 1'b0);
			drain(1);
		end
		drain(0);
		// Bases share a small window so reads hit earlier writes
		test_name = "random_mix";
		for (int i = 0; i < 40; i++) begin
			r    = rand_bits(16);
			base = {20'h00010, r[11:0]};
			send_cmd(r[15], base, r[14:12], 1'b0);
			drain(3);
		end
		drain(0);
		test_name = "back_to_back";
		for (int i = 0; i < 8; i++) begin
			r    = rand_bits(14);
			base = {20'h00010, r[11:0]};
			send_cmd(1'b1, base, {1'b0, r[13:12]}, 1'b1);
		end
		drain(0);
		repeat (20) @(posedge clk);
		if (app_q.size() != 0 || rd_q.size() != 0 || ret_q.size() != 0) begin
			$display("Traffic left at the end: %0d memory commands, %0d read strips, %0d returns",
				app_q.size(), rd_q.size(), ret_q.size());
			left_errs++;
		end
		$display("Error counts: memory %0d, read %0d, done %0d, leftover %0d",
			app_errs, rd_errs, done_errs, left_errs);
		if (app_errs + rd_errs + done_errs + left_errs == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// ==================================================
	// Memory model
	// ==================================================

	// Commands are taken mid-cycle and read returns are driven on the rising edge
	// A drawn latency of 0 to 7 puts the return 2 to 9 edges after the issue edge
	always @(negedge clk) begin
		int lat;
		int due;
		if (!rst && app_strobe) begin
			if (app_cmd.we) begin
				mem[app_cmd.addr[31:4]] = app_cmd.wdata;
			end else begin
				lat = 0;
				for (int i = 0; i < 3; i++) begin
					lat = (lat << 1) | int'(mem_lfsr[0]);
					mem_lfsr = lfsr_step(mem_lfsr);
				end
				// Returns stay in issue order whatever latency is drawn
				due = cyc + 1 + lat;
				if (due <= last_due)
					due = last_due + 1;
				last_due = due;
				ret_q.push_back(mem.exists(app_cmd.addr[31:4]) ? mem[app_cmd.addr[31:4]]
					: fill_pattern(app_cmd.addr[31:4]));
				due_q.push_back(due);
			end
		end
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (due_q.size() > 0 && due_q[0] <= cyc) begin
			app_rd_strobe <= 1'b1;
			app_rdata     <= ret_q.pop_front();
			void'(due_q.pop_front());
		end else begin
			app_rd_strobe <= 1'b0;
		end
	end

	// ==================================================
	// Comparison
	// ==================================================

	always @(negedge clk) begin
		mpmc_app_cmd_t ea;
		mpmc_rdata_t   er;
		mpmc_done_t    ed;
		if (!rst && app_strobe) begin
			if (app_q.size() == 0) begin
				$display("Memory command to %h was not expected in test %s",
					app_cmd.addr, test_name);
				app_errs++;
			end else begin
				ea = app_q.pop_front();
				if (app_cmd != ea) begin
					$display("ERROR %s: app_cmd expected %h actual %h", test_name, ea, app_cmd);
					app_errs++;
				end
			end
		end
		if (!rst && rd_strobe) begin
			if (rd_q.size() == 0) begin
				$display("Read strip with tag %h was not expected in test %s", rd.tag, test_name);
				rd_errs++;
			end else begin
				er = rd_q.pop_front();
				if (rd != er) begin
					$display("ERROR %s: rd expected %h actual %h", test_name, er, rd);
					rd_errs++;
				end
			end
		end
		// Writes and reads finish in their own order, so each has its own queue
		if (!rst && done_strobe) begin
			if ((done.we && wr_done_q.size() == 0) || (!done.we && rd_done_q.size() == 0)) begin
				$display("Done for tag %h was not expected in test %s", done.tag, test_name);
				done_errs++;
			end else begin
				ed = done.we ? wr_done_q.pop_front() : rd_done_q.pop_front();
				if (done != ed) begin
					$display("ERROR %s: done expected %h actual %h", test_name, ed, done);
					done_errs++;
				end
			end
		end
	end

	initial begin
		repeat (10 + TOTAL_CMDS * 40) @(posedge clk);
		$display("Timeout: the run did not finish in test %s", test_name);
		$display("Regression failed");
		$finish;
	end

endmodule
